/* source/camera_spi_pkg.sv */
package camera_spi_pkg;

  // camera bus and pixel format
  localparam int byte_w = 8;  // parallel camera data
  localparam int pixel_w = 16;  // one pixel, also bits per lane per packet

  // counters sized for the 1280x720 sensor
  localparam int hcount_w = 11;
  localparam int vcount_w = 10;

  // spi link
  localparam int lanes = 6;  // data lanes, also pixels per packet
  localparam int dclk_period = 6;  // clk_camera cycles per bit
  localparam int dclk_half = dclk_period / 2;  // dclk low for the first half

  typedef logic [pixel_w-1:0] pixel_t;

  // element 0 holds the oldest pixel of the packet
  typedef pixel_t [lanes-1:0] packet_t;

  typedef logic [$clog2(pixel_w)-1:0] bit_count_t;

  // cycle divider inside one bit period
  typedef logic [$clog2(dclk_period)-1:0] div_count_t;

endpackage

/* source/pixel_reconstruct.sv */
module pixel_reconstruct (
  input  logic                                  clk_camera,
  input  logic                                  sys_rst_camera,
  input  logic                                  cam_pclk,
  input  logic                                  cam_hsync,
  input  logic                                  cam_vsync,
  input  logic [camera_spi_pkg::byte_w-1:0]     camera_d,
  output logic                                  pixel_valid,
  output camera_spi_pkg::pixel_t                pixel_data,
  output logic [camera_spi_pkg::hcount_w-1:0]   hcount,
  output logic [camera_spi_pkg::vcount_w-1:0]   vcount
);

  // two-flop synchronizers with bit 1 as the settled stage
  logic [1:0] pclk_sync;
  logic [1:0] hsync_sync;
  logic [1:0] vsync_sync;
  logic [camera_spi_pkg::byte_w-1:0] d_meta;
  logic [camera_spi_pkg::byte_w-1:0] d_sync;

  // edge detect stage
  logic pclk_last;  // settled pclk one cycle back
  logic byte_stb;  // one cycle per pclk rising edge
  logic hs_q;
  logic hs_last;
  logic vs_q;
  logic [camera_spi_pkg::byte_w-1:0] byte_q;  // byte aligned with byte_stb
  logic line_end;

  // pairing and counting
  logic high_half;  // high byte of a pair already held
  logic pixel_done;
  logic [camera_spi_pkg::byte_w-1:0] high_byte;
  logic [camera_spi_pkg::hcount_w-1:0] h_cnt;  // completed pixels in this line
  logic [camera_spi_pkg::vcount_w-1:0] v_cnt;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pclk_sync <= '0;
      hsync_sync <= '0;
      vsync_sync <= '0;
      pclk_last <= 1'b0;
      byte_stb <= 1'b0;
      hs_q <= 1'b0;
      hs_last <= 1'b0;
      vs_q <= 1'b0;
    end else begin
      pclk_sync <= {pclk_sync[0], cam_pclk};
      hsync_sync <= {hsync_sync[0], cam_hsync};
      vsync_sync <= {vsync_sync[0], cam_vsync};
      pclk_last <= pclk_sync[1];
      byte_stb <= pclk_sync[1] & ~pclk_last;  // rising edge of pclk
      hs_q <= hsync_sync[1];
      hs_last <= hs_q;
      vs_q <= vsync_sync[1];
    end
  end

  // camera data takes the same three stages as byte_stb
  always_ff @(posedge clk_camera) begin
    d_meta <= camera_d;
    d_sync <= d_meta;
    byte_q <= d_sync;
  end

  assign line_end = hs_last & ~hs_q;  // falling edge of hsync
  assign pixel_done = hs_q && byte_stb && high_half;  // low byte arrives

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pixel_valid <= 1'b0;
      high_half <= 1'b0;
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      pixel_valid <= pixel_done;
      if (!hs_q) begin
        high_half <= 1'b0;  // drop a half pair at line end
        h_cnt <= '0;
      end else if (byte_stb) begin
        high_half <= ~high_half;
        if (high_half) h_cnt <= h_cnt + 1'b1;
      end
      if (vs_q) v_cnt <= '0;  // held clear through vsync
      else if (line_end) v_cnt <= v_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (hs_q && byte_stb && !high_half) high_byte <= byte_q;  // first byte is high
    if (pixel_done) begin
      pixel_data <= {high_byte, byte_q};
      hcount <= h_cnt;  // index of this pixel in the line
      vcount <= v_cnt;
    end
  end

endmodule

/* source/pixel_packer.sv */
module pixel_packer (
  input  logic                                  clk_camera,
  input  logic                                  sys_rst_camera,
  input  logic                                  pixel_valid,
  input  camera_spi_pkg::pixel_t                pixel_data,
  input  logic [camera_spi_pkg::hcount_w-1:0]   hcount,
  input  logic [camera_spi_pkg::vcount_w-1:0]   vcount,
  output logic                                  packet_valid,
  output camera_spi_pkg::packet_t               packet_data,
  output logic                                  pack_overflow,
  input  logic                                  packet_ready
);

  camera_spi_pkg::packet_t collect;  // pixels gathered so far
  camera_spi_pkg::packet_t shifted;  // collector with the new pixel on top
  logic [$clog2(camera_spi_pkg::lanes)-1:0] fill;  // kept pixels in collector

  logic keep;  // pixel survives the 2x downsample
  logic last_slot;  // this pixel completes a packet
  logic slot_free;  // waiting register can take a packet this cycle
  logic handshake;

  // keep even columns of even rows only
  assign keep = pixel_valid && !hcount[0] && !vcount[0];

  // newest at the top, element 0 ends up oldest
  assign shifted = {pixel_data, collect[camera_spi_pkg::lanes-1:1]};

  assign last_slot = (fill == camera_spi_pkg::lanes - 1);
  assign handshake = packet_valid && packet_ready;
  assign slot_free = !packet_valid || packet_ready;  // empty or leaving now

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      fill <= '0;
      packet_valid <= 1'b0;
      pack_overflow <= 1'b0;
    end else begin
      if (handshake) packet_valid <= 1'b0;
      if (keep) begin
        if (last_slot) begin
          fill <= '0;  // restart empty, kept or dropped
          if (slot_free) packet_valid <= 1'b1;
          else pack_overflow <= 1'b1;  // sticky until reset
        end else begin
          fill <= fill + 1'b1;
        end
      end
    end
  end

  // payload registers
  always_ff @(posedge clk_camera) begin
    if (keep) collect <= shifted;
    if (keep && last_slot && slot_free) packet_data <= shifted;  // stable until taken
  end

endmodule

/* source/spi_lane.sv */
module spi_lane (
  input  logic                    clk_camera,
  input  logic                    sys_rst_camera,
  input  logic                    load,
  input  logic                    shift,
  input  camera_spi_pkg::pixel_t  word,
  output logic                    lane_bit
);

  camera_spi_pkg::pixel_t sreg;  // bits still to send, MSB on the wire

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      sreg <= '0;  // lane idles at 0
    end else if (load) begin
      sreg <= word;
    end else if (shift) begin
      sreg <= {sreg[camera_spi_pkg::pixel_w-2:0], 1'b0};  // zeros fill behind
    end
  end

  // after 16 shifts the register is empty again, so the lane rests at 0
  assign lane_bit = sreg[camera_spi_pkg::pixel_w-1];

endmodule

/* source/spi_link_control.sv */
module spi_link_control (
  input  logic clk_camera,
  input  logic sys_rst_camera,
  input  logic packet_valid,
  output logic packet_ready,
  output logic lane_load,
  output logic lane_shift,
  output logic dclk,
  output logic cs
);

  typedef enum logic {
    st_idle,
    st_xfer
  } state_t;

  state_t state;
  camera_spi_pkg::div_count_t div;  // cycle inside the current bit
  camera_spi_pkg::bit_count_t bit_cnt;  // bits already started
  logic bit_end;  // last cycle of a bit period
  logic last_bit;

  assign packet_ready = (state == st_idle);
  assign lane_load = packet_valid && packet_ready;  // lanes copy on accept
  assign bit_end = (state == st_xfer) && (div == camera_spi_pkg::dclk_period - 1);
  assign last_bit = (bit_cnt == camera_spi_pkg::pixel_w - 1);
  assign lane_shift = bit_end;  // next bit shows while dclk is low

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      state <= st_idle;
      div <= '0;
      bit_cnt <= '0;
      cs <= 1'b1;
      dclk <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (packet_valid) begin
            state <= st_xfer;
            cs <= 1'b0;  // one cycle after the handshake
            div <= '0;
            bit_cnt <= '0;
            dclk <= 1'b0;
          end
        end
        st_xfer: begin
          if (bit_end) begin
            div <= '0;
            dclk <= 1'b0;  // falls at the start of each bit
            if (last_bit) begin
              state <= st_idle;
              cs <= 1'b1;  // transfer done after bit 16
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            div <= div + 1'b1;
            // high for the second half of the bit
            if (div == camera_spi_pkg::dclk_half - 1) dclk <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* source/camera_spi_top.sv */
module camera_spi_top (
  input  logic                                clk_camera,
  input  logic                                sys_rst_camera,
  input  logic [camera_spi_pkg::byte_w-1:0]   camera_d,
  input  logic                                cam_pclk,
  input  logic                                cam_hsync,
  input  logic                                cam_vsync,
  output logic [camera_spi_pkg::lanes-1:0]    cipo,
  output logic                                dclk,
  output logic                                cs,
  output logic                                pack_overflow
);

  // camera side
  logic pixel_valid;
  camera_spi_pkg::pixel_t pixel_data;
  logic [camera_spi_pkg::hcount_w-1:0] hcount;
  logic [camera_spi_pkg::vcount_w-1:0] vcount;

  // packet handshake and lane strobes
  logic packet_valid;
  logic packet_ready;
  camera_spi_pkg::packet_t packet_data;
  logic lane_load;
  logic lane_shift;

  pixel_reconstruct u_reconstruct (
    .clk_camera    (clk_camera),
    .sys_rst_camera(sys_rst_camera),
    .cam_pclk      (cam_pclk),
    .cam_hsync     (cam_hsync),
    .cam_vsync     (cam_vsync),
    .camera_d      (camera_d),
    .pixel_valid   (pixel_valid),
    .pixel_data    (pixel_data),
    .hcount        (hcount),
    .vcount        (vcount)
  );

  pixel_packer u_packer (
    .clk_camera    (clk_camera),
    .sys_rst_camera(sys_rst_camera),
    .pixel_valid   (pixel_valid),
    .pixel_data    (pixel_data),
    .hcount        (hcount),
    .vcount        (vcount),
    .packet_valid  (packet_valid),
    .packet_data   (packet_data),
    .pack_overflow (pack_overflow),
    .packet_ready  (packet_ready)
  );

  spi_link_control u_link (
    .clk_camera    (clk_camera),
    .sys_rst_camera(sys_rst_camera),
    .packet_valid  (packet_valid),
    .packet_ready  (packet_ready),
    .lane_load     (lane_load),
    .lane_shift    (lane_shift),
    .dclk          (dclk),
    .cs            (cs)
  );

  // lane i carries packet element i
  for (genvar i = 0; i < camera_spi_pkg::lanes; i++) begin : g_lane
    spi_lane u_lane (
      .clk_camera    (clk_camera),
      .sys_rst_camera(sys_rst_camera),
      .load          (lane_load),
      .shift         (lane_shift),
      .word          (packet_data[i]),
      .lane_bit      (cipo[i])
    );
  end

endmodule

/* verif/camera_spi_sva.sv */
module camera_spi_sva (
  input logic                             clk_camera,
  input logic                             sys_rst_camera,
  input logic [camera_spi_pkg::lanes-1:0] cipo,
  input logic                             dclk,
  input logic                             cs,
  input logic                             pack_overflow
);

  // bit clock only runs inside a transfer
  dclk_idle_low: assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera) cs |-> !dclk
  ) else $error("dclk is high while cs is high");

  // receiver samples on the high phase
  cipo_stable: assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera) dclk |-> $stable(cipo)
  ) else $error("cipo changed while dclk was high");

  cipo_idle_zero: assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera) cs |-> (cipo == '0)
  ) else $error("cipo is not zero between transfers");  // lanes drain to 0

  // sticky flag, only reset clears it
  overflow_sticky: assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera) $past(pack_overflow) |-> pack_overflow
  ) else $error("pack_overflow fell outside reset");

endmodule

bind camera_spi_top camera_spi_sva u_sva (
  .clk_camera    (clk_camera),
  .sys_rst_camera(sys_rst_camera),
  .cipo          (cipo),
  .dclk          (dclk),
  .cs            (cs),
  .pack_overflow (pack_overflow)
);

/* verif/camera_spi_tb.sv */
module camera_spi_tb;

  localparam int clk_period = 100;
  localparam int drive_delay = 10;  // inputs move this long after the rising edge
  localparam int quiet_cycles = 150;  // cs high this long means the link has drained
  localparam int idle_limit = 20000;

  logic clk_camera;
  logic sys_rst_camera;
  logic [camera_spi_pkg::byte_w-1:0] camera_d;
  logic cam_pclk;
  logic cam_hsync;
  logic cam_vsync;
  logic [camera_spi_pkg::lanes-1:0] cipo;
  logic dclk;
  logic cs;
  logic pack_overflow;

  camera_spi_pkg::packet_t got_q[$];  // rebuilt from the spi lanes
  camera_spi_pkg::packet_t trace_q[$];  // expected packets listed in the trace
  camera_spi_pkg::packet_t model_q[$];  // predicted from the bytes actually sent
  camera_spi_pkg::packet_t collect;
  int fill;
  bit odd_pixels[camera_spi_pkg::pixel_t];  // values sent on an odd row or column
  logic [camera_spi_pkg::byte_w-1:0] line_bytes[$];
  int row;  // line index inside the current frame
  bit line_open;
  bit stopped;  // timeout or missing trace
  int errors;
  int tests_run;
  int tests_failed;

  // spi monitor
  camera_spi_pkg::packet_t rx;
  int rx_bits;
  logic dclk_q = 1'b0;
  logic cs_q = 1'b1;

  camera_spi_top DUT (.*);

  initial begin
    clk_camera = 1'b0;
    forever #(clk_period / 2) clk_camera = ~clk_camera;
  end

  // outputs are settled at the falling edge
  always @(negedge clk_camera) begin
    if (cs_q && !cs) begin
      rx = '0;  // new cs-low window
      rx_bits = 0;
    end
    if (!cs && dclk && !dclk_q) begin
      for (int i = 0; i < camera_spi_pkg::lanes; i++) begin
        rx[i] = {rx[i][camera_spi_pkg::pixel_w-2:0], cipo[i]};  // msb arrives first
      end
      rx_bits++;
    end
    if (!cs_q && cs) begin
      if (rx_bits != camera_spi_pkg::pixel_w) begin
        $display("a transfer ended after %0d dclk edges instead of %0d",
                 rx_bits, camera_spi_pkg::pixel_w);
        errors++;
      end
      got_q.push_back(rx);
    end
    dclk_q = dclk;
    cs_q = cs;
  end

  task automatic check_packet(input string name, input camera_spi_pkg::packet_t got,
                              input camera_spi_pkg::packet_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_lanes(input logic [camera_spi_pkg::lanes-1:0] got,
                             input logic [camera_spi_pkg::lanes-1:0] exp);
    if (got !== exp) begin
      $display("error cipo got %h expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge clk_camera);
    #drive_delay;
  endtask

  // element 0 is the oldest kept pixel
  function automatic void predict_pixel(input camera_spi_pkg::pixel_t pix);
    collect[fill] = pix;
    fill++;
    if (fill == camera_spi_pkg::lanes) begin
      model_q.push_back(collect);
      fill = 0;
    end
  endfunction

  task automatic send_byte(input int s, input logic [camera_spi_pkg::byte_w-1:0] b);
    camera_d = b;
    cam_pclk = 1'b0;
    tick(s);
    cam_pclk = 1'b1;  // camera byte taken on this edge
    tick(s);
    line_bytes.push_back(b);
  endtask

  task automatic close_line();
    camera_spi_pkg::pixel_t pix;
    if (line_open) begin
      cam_hsync = 1'b0;
      tick(8);
      for (int k = 0; k + 1 < line_bytes.size(); k += 2) begin
        pix = {line_bytes[k], line_bytes[k + 1]};  // high byte first
        if (row % 2 == 0 && (k / 2) % 2 == 0) predict_pixel(pix);
        else odd_pixels[pix] = 1'b1;
      end
      line_bytes.delete();
      row++;
      line_open = 1'b0;
    end
  endtask

  task automatic send_line(input int s, input int n, input camera_spi_pkg::pixel_t base);
    camera_spi_pkg::pixel_t pix;
    close_line();
    cam_hsync = 1'b1;
    tick(4);
    line_open = 1'b1;
    for (int k = 0; k < n; k++) begin
      pix = base + camera_spi_pkg::pixel_t'(k);
      send_byte(s, pix[15:8]);
      send_byte(s, pix[7:0]);
    end
  endtask

  task automatic frame_pulse();
    close_line();
    cam_vsync = 1'b1;
    tick(4);
    cam_vsync = 1'b0;
    tick(4);
    row = 0;
  endtask

  task automatic wait_idle();
    int quiet;
    int waited;
    quiet = 0;
    waited = 0;
    while (quiet < quiet_cycles && !stopped) begin
      tick(1);
      waited++;
      quiet = cs ? quiet + 1 : 0;
      if (waited >= idle_limit) begin
        $display("timeout, the spi link did not go idle within %0d cycles", idle_limit);
        stopped = 1'b1;
      end
    end
  endtask

  task automatic report_test(input int id, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d passed", id);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", id, errors - errors_before);
    end
  endtask

  task automatic finish_test(input int id, input bit burst, input int errors_before);
    int j;
    close_line();
    wait_idle();
    if (!stopped) begin
      if (model_q.size() != trace_q.size()) begin
        $display("test %0d lists %0d packets but the camera bytes give %0d",
                 id, trace_q.size(), model_q.size());
        errors++;
      end
      for (int i = 0; i < model_q.size() && i < trace_q.size(); i++)
        check_packet("trace packet", trace_q[i], model_q[i]);
      foreach (got_q[i]) begin
        for (int e = 0; e < camera_spi_pkg::lanes; e++) begin
          if (odd_pixels.exists(got_q[i][e])) begin
            $display("error cipo pixel %h comes from an odd row or column", got_q[i][e]);
            errors++;
          end
        end
      end
      if (!burst) begin
        if (got_q.size() != trace_q.size()) begin
          $display("the link sent %0d packets instead of %0d", got_q.size(), trace_q.size());
          errors++;
        end
        for (int i = 0; i < got_q.size() && i < trace_q.size(); i++)
          check_packet("cipo packet", got_q[i], trace_q[i]);
      end else begin
        j = 0;  // dropped packets are skipped but the order must hold
        foreach (got_q[i]) begin
          while (j < trace_q.size() && trace_q[j] !== got_q[i]) j++;
          if (j == trace_q.size()) begin
            $display("error cipo packet %h is not in the predicted order", got_q[i]);
            errors++;
          end else begin
            j++;
          end
        end
        if (got_q.size() == 0 || got_q.size() >= trace_q.size()) begin
          $display("the burst sent %0d of %0d packets, a drop was expected",
                   got_q.size(), trace_q.size());
          errors++;
        end
      end
      check_flag("pack_overflow", pack_overflow, burst);
      check_flag("dclk", dclk, 1'b0);
      check_lanes(cipo, '0);
    end
    report_test(id, errors_before);
  endtask

  initial begin
    int fd;
    int code;
    int cur_id;
    bit cur_burst;
    int errors_before;
    int s;
    int n;
    int ch;
    logic [7:0] kind;
    logic [15:0] value;
    camera_spi_pkg::packet_t pk;
    sys_rst_camera = 1'b1;
    camera_d = '0;
    cam_pclk = 1'b0;
    cam_hsync = 1'b0;
    cam_vsync = 1'b0;
    fill = 0;
    row = 0;
    line_open = 1'b0;
    stopped = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cur_id = 0;
    cur_burst = 1'b0;
    tick(5);
    sys_rst_camera = 1'b0;

    // idle levels straight out of reset
    errors_before = errors;
    check_flag("cs", cs, 1'b1);
    check_flag("dclk", dclk, 1'b0);
    check_lanes(cipo, '0);
    check_flag("pack_overflow", pack_overflow, 1'b0);
    report_test(1, errors_before);

    fd = $fopen("verif/camera_spi_trace.txt", "r");
    if (fd == 0) begin
      $display("the trace file verif/camera_spi_trace.txt could not be opened");
      stopped = 1'b1;
    end
    code = (fd != 0) ? $fscanf(fd, " %c", kind) : 0;
    while (code == 1 && !stopped) begin
      case (kind)
        "#": begin
          ch = 0;
          while (ch != "\n" && ch != -1) ch = $fgetc(fd);
        end
        "T": begin
          if (cur_id != 0) finish_test(cur_id, cur_burst, errors_before);
          code = $fscanf(fd, " %d %d", cur_id, n);
          cur_burst = (n != 0);
          errors_before = errors;
          trace_q.delete();
          model_q.delete();
          got_q.delete();
          odd_pixels.delete();
        end
        "F": frame_pulse();
        "L": begin
          code = $fscanf(fd, " %d %d %h", s, n, value);
          send_line(s, n, value);
        end
        "B": begin
          code = $fscanf(fd, " %d %h", s, value);
          send_byte(s, value[7:0]);
        end
        "E": close_line();
        "P": begin
          for (int i = 0; i < camera_spi_pkg::lanes; i++) begin
            code = $fscanf(fd, " %h", value);
            pk[i] = value;
          end
          trace_q.push_back(pk);
        end
        default: begin
          $display("the trace holds an unknown record type %c", kind);
          errors++;
        end
      endcase
      code = $fscanf(fd, " %c", kind);
    end
    if (cur_id != 0 && !stopped) finish_test(cur_id, cur_burst, errors_before);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && !stopped) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* verif/camera_spi_trace.txt */
# T test burst | F vsync pulse | L spacing pixels base | B spacing byte | E line end
# P six expected pixels, element 0 first; spacing is clk_camera cycles per pclk half period
T 2 0
F
L 4 12 2000
L 4 12 2100
L 4 10 2200
B 4 a5
B 4 3c
B 4 5a
B 4 c3
L 4 12 2300
E
P 2000 2002 2004 2006 2008 200a
P 2200 2202 2204 2206 2208 a53c
T 3 0
F
L 4 12 3000
L 4 12 3100
L 4 12 3200
E
P 3000 3002 3004 3006 3008 300a
P 3200 3202 3204 3206 3208 320a
T 4 0
F
L 4 12 4000
F
L 4 12 4100
L 4 12 4200
L 4 12 4300
E
P 4000 4002 4004 4006 4008 400a
P 4100 4102 4104 4106 4108 410a
P 4300 4302 4304 4306 4308 430a
T 5 1
F
L 1 48 5000
E
P 5000 5002 5004 5006 5008 500a
P 500c 500e 5010 5012 5014 5016
P 5018 501a 501c 501e 5020 5022
P 5024 5026 5028 502a 502c 502e

/* camera_spi_top.f */
source/camera_spi_pkg.sv
source/pixel_reconstruct.sv
source/pixel_packer.sv
source/spi_lane.sv
source/spi_link_control.sv
source/camera_spi_top.sv
verif/camera_spi_sva.sv
verif/camera_spi_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the camera to spi testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module camera_spi_tb -f camera_spi_top.f -o camera_spi_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/camera_spi_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
